// File: design/icache_pkg.sv
// icache package
// cache geometry, address fields, fill packet and request types
package icache_pkg;

  localparam int vaddr_width = 32;
  localparam int paddr_width = 32;
  localparam int page_offset_width = 12;
  localparam int ptag_width = paddr_width - page_offset_width;

  // one word per way in each block
  localparam int ways = 4;
  localparam int way_width = 2;
  localparam int sets = 64;
  localparam int index_width = 6;

  localparam int dword_width = 64;
  localparam int instr_width = 32;
  localparam int byte_offset_width = 3;
  localparam int word_offset_width = 2;
  localparam int block_offset_width = byte_offset_width + word_offset_width;
  localparam int tag_width = paddr_width - index_width - block_offset_width;
  localparam int block_width = ways * dword_width;

  typedef logic [dword_width-1:0] dword_t;
  typedef logic [tag_width-1:0]   tag_t;
  typedef logic [way_width-1:0]   way_t;
  typedef logic [index_width-1:0] index_t;

  // pseudo-LRU tree, bit0 is the root
  typedef logic [ways-2:0] lru_bits_t;

  typedef enum logic [1:0] {
    tag_set_clear  = 2'd0,
    tag_invalidate = 2'd1,
    tag_set_tag    = 2'd2
  } tag_op_e;

  typedef struct packed {
    tag_op_e opcode;
    index_t  index;
    way_t    way;
    tag_t    tag;
  } tag_pkt_s;

  // word 0 of the block sits in the low bits
  typedef struct packed {
    index_t                      index;
    way_t                        way;
    logic [ways-1:0][dword_width-1:0] block;
  } data_pkt_s;

  typedef struct packed {
    logic [paddr_width-1:0] addr;
  } cache_req_s;

  typedef struct packed {
    way_t repl_way;
  } cache_meta_s;

endpackage

// File: design/icache_tag_array.sv
// icache tag array
// per-set tags and valid bits, synchronous read, packet-driven writes
`timescale 1ns/10ps

module icache_tag_array (
  input  logic                                       clk_i
  , input  logic                                     reset_i
  , input  logic                                     rd_v_i
  , input  icache_pkg::index_t                       rd_index_i
  , input  logic                                     pkt_v_i
  , input  icache_pkg::tag_pkt_s                     pkt_i
  , output icache_pkg::tag_t [icache_pkg::ways-1:0]  tags_o
  , output logic [icache_pkg::ways-1:0]              valid_o
);

  import icache_pkg::*;

  tag_t             tag_mem   [sets][ways];
  logic [ways-1:0]  valid_mem [sets];
  logic             wr_en;

  // reads own the array in a lookup cycle
  assign wr_en = pkt_v_i & ~rd_v_i;

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      for (int w = 0; w < ways; w++) begin
        tags_o[w] <= tag_mem[rd_index_i][w];
      end
      valid_o <= valid_mem[rd_index_i];
    end
    if (wr_en) begin
      case (pkt_i.opcode)
        tag_set_clear: begin
          for (int w = 0; w < ways; w++) begin
            tag_mem[pkt_i.index][w] <= '0;
          end
        end
        tag_set_tag: tag_mem[pkt_i.index][pkt_i.way] <= pkt_i.tag;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets; s++) begin
        valid_mem[s] <= '0;
      end
    end else if (wr_en) begin
      case (pkt_i.opcode)
        tag_set_clear:  valid_mem[pkt_i.index] <= '0;
        tag_invalidate: valid_mem[pkt_i.index][pkt_i.way] <= 1'b0;
        tag_set_tag:    valid_mem[pkt_i.index][pkt_i.way] <= 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: design/icache_data_banks.sv
// icache data banks
// four dword banks, bank b holds word (way ^ b) of each block
`timescale 1ns/10ps

module icache_data_banks (
  input  logic                                          clk_i
  , input  logic                                        reset_i
  , input  logic                                        rd_v_i
  , input  icache_pkg::index_t                          rd_index_i
  , input  logic [icache_pkg::word_offset_width-1:0]    rd_word_i
  , input  logic                                        pkt_v_i
  , input  icache_pkg::data_pkt_s                       pkt_i
  , output icache_pkg::dword_t [icache_pkg::ways-1:0]   words_o
);

  import icache_pkg::*;

  localparam int bank_els = sets * ways;

  logic rd_en;
  logic wr_en;

  // lookup read wins over a fill
  assign rd_en = rd_v_i & ~reset_i;
  assign wr_en = pkt_v_i & ~rd_v_i & ~reset_i;

  for (genvar b = 0; b < ways; b++) begin : g_bank
    dword_t mem [bank_els];
    dword_t rd_q;
    way_t   wr_word;

    // every bank gets a different word of the block
    assign wr_word = pkt_i.way ^ way_t'(b);

    always_ff @(posedge clk_i) begin
      if (rd_en) begin
        rd_q <= mem[{rd_index_i, rd_word_i}];
      end else if (wr_en) begin
        mem[{pkt_i.index, wr_word}] <= pkt_i.block[wr_word];
      end
    end

    assign words_o[b] = rd_q;
  end

endmodule

// File: design/icache_lru.sv
// icache replacement state
// tree pseudo-LRU per set, hit update and registered victim way
`timescale 1ns/10ps

module icache_lru (
  input  logic                              clk_i
  , input  logic                            reset_i
  , input  icache_pkg::index_t              index_i
  , input  logic                            hit_v_i
  , input  icache_pkg::way_t                hit_way_i
  , input  logic [icache_pkg::ways-1:0]     valid_i
  , output icache_pkg::way_t                victim_way_o
);

  import icache_pkg::*;

  lru_bits_t lru_r [sets];
  lru_bits_t lru_cur;
  way_t      victim_n;

  assign lru_cur = lru_r[index_i];

  // point the tree away from the way just used
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets; s++) begin
        lru_r[s] <= '0;
      end
    end else if (hit_v_i) begin
      lru_r[index_i][0] <= ~hit_way_i[1];
      lru_r[index_i][1 + hit_way_i[1]] <= ~hit_way_i[0];
    end
  end

  always_comb begin
    victim_n = {lru_cur[0], lru_cur[1 + lru_cur[0]]};
    // lowest invalid way beats the tree
    for (int i = ways - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        victim_n = way_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    victim_way_o <= victim_n;
  end

endmodule

// File: design/icache_miss_ctrl.sv
// icache miss control
// fill request pulse, metadata strobe and outstanding-miss tracker
`timescale 1ns/10ps

module icache_miss_ctrl (
  input  logic                                   clk_i
  , input  logic                                 reset_i
  , input  logic                                 miss_i
  , input  logic [icache_pkg::paddr_width-1:0]   miss_addr_i
  , input  logic                                 req_ready_i
  , input  logic                                 complete_i
  , input  icache_pkg::way_t                     victim_way_i
  , output icache_pkg::cache_req_s               req_o
  , output logic                                 req_v_o
  , output icache_pkg::cache_meta_s              meta_o
  , output logic                                 meta_v_o
  , output logic                                 lookup_ready_o
);

  import icache_pkg::*;

  logic tracker_r;

  // no request without ready, the requester replays instead
  assign req_v_o = miss_i & req_ready_i;
  assign req_o.addr = {miss_addr_i[paddr_width-1:block_offset_width],
                       {block_offset_width{1'b0}}};

  assign meta_o.repl_way = victim_way_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_v_o  <= 1'b0;
      tracker_r <= 1'b0;
    end else begin
      meta_v_o <= req_v_o;
      if (req_v_o) begin
        tracker_r <= 1'b1;
      end else if (complete_i) begin
        tracker_r <= 1'b0;
      end
    end
  end

  assign lookup_ready_o = req_ready_i & ~req_v_o & ~tracker_r;

endmodule

// File: design/icache.sv
// 4-way VIPT instruction cache
// TL stage reads the arrays, TV stage compares physical tags
`timescale 1ns/10ps

module icache (
  input  logic                                   clk_i
  , input  logic                                 reset_i

  , input  logic [icache_pkg::vaddr_width-1:0]   vaddr_i
  , input  logic                                 vaddr_v_i
  , output logic                                 vaddr_ready_o

  , input  logic [icache_pkg::ptag_width-1:0]    ptag_i
  , input  logic                                 ptag_v_i
  , input  logic                                 poison_i

  , output logic [icache_pkg::instr_width-1:0]   data_o
  , output logic                                 data_v_o
  , output logic                                 miss_o

  , output icache_pkg::cache_req_s               cache_req_o
  , output logic                                 cache_req_v_o
  , input  logic                                 cache_req_ready_i
  , output icache_pkg::cache_meta_s              cache_meta_o
  , output logic                                 cache_meta_v_o
  , input  logic                                 cache_req_complete_i

  , input  icache_pkg::data_pkt_s                data_pkt_i
  , input  logic                                 data_pkt_v_i
  , output logic                                 data_pkt_ready_o
  , input  icache_pkg::tag_pkt_s                 tag_pkt_i
  , input  logic                                 tag_pkt_v_i
  , output logic                                 tag_pkt_ready_o
);

  import icache_pkg::*;

  logic                          tl_we;
  logic                          tv_we;
  logic                          v_tl_r;
  logic [page_offset_width-1:0]  vaddr_tl_r;
  tag_t [ways-1:0]               tags_tl;
  logic [ways-1:0]               valid_tl;
  dword_t [ways-1:0]             words_tl;

  logic                          v_tv_r;
  logic [paddr_width-1:0]        paddr_tv_r;
  tag_t [ways-1:0]               tags_tv_r;
  logic [ways-1:0]               valid_tv_r;
  dword_t [ways-1:0]             words_tv_r;

  logic [ways-1:0]               hit_v;
  logic                          hit;
  way_t                          hit_way;
  logic                          miss_tv;
  way_t                          victim_way;
  dword_t                        word_sel;

  assign tl_we = vaddr_v_i & vaddr_ready_o;
  assign data_pkt_ready_o = ~tl_we;
  assign tag_pkt_ready_o  = ~tl_we;

  icache_tag_array tag_array_i (
    .clk_i       (clk_i)
    , .reset_i   (reset_i)
    , .rd_v_i    (tl_we)
    , .rd_index_i(vaddr_i[block_offset_width +: index_width])
    , .pkt_v_i   (tag_pkt_v_i)
    , .pkt_i     (tag_pkt_i)
    , .tags_o    (tags_tl)
    , .valid_o   (valid_tl)
  );

  icache_data_banks data_banks_i (
    .clk_i       (clk_i)
    , .reset_i   (reset_i)
    , .rd_v_i    (tl_we)
    , .rd_index_i(vaddr_i[block_offset_width +: index_width])
    , .rd_word_i (vaddr_i[byte_offset_width +: word_offset_width])
    , .pkt_v_i   (data_pkt_v_i)
    , .pkt_i     (data_pkt_i)
    , .words_o   (words_tl)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
    end else begin
      v_tl_r <= tl_we;
    end
    if (tl_we) begin
      vaddr_tl_r <= vaddr_i[page_offset_width-1:0];
    end
  end

  // translation must land during TL or the lookup is dropped
  assign tv_we = v_tl_r & ptag_v_i & ~poison_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tv_r <= 1'b0;
    end else begin
      v_tv_r <= tv_we;
    end
    if (tv_we) begin
      paddr_tv_r <= {ptag_i, vaddr_tl_r};
      tags_tv_r  <= tags_tl;
      valid_tv_r <= valid_tl;
      words_tv_r <= words_tl;
    end
  end

  for (genvar i = 0; i < ways; i++) begin : g_cmp
    assign hit_v[i] = valid_tv_r[i]
      & (tags_tv_r[i] == paddr_tv_r[paddr_width-1 -: tag_width]);
  end

  // lowest hitting way
  always_comb begin
    hit_way = '0;
    for (int i = ways - 1; i >= 0; i--) begin
      if (hit_v[i]) begin
        hit_way = way_t'(i);
      end
    end
  end

  assign hit      = |hit_v;
  assign miss_tv  = v_tv_r & ~hit;
  assign data_v_o = v_tv_r & hit;
  assign miss_o   = miss_tv;

  icache_lru lru_i (
    .clk_i         (clk_i)
    , .reset_i     (reset_i)
    , .index_i     (paddr_tv_r[block_offset_width +: index_width])
    , .hit_v_i     (data_v_o)
    , .hit_way_i   (hit_way)
    , .valid_i     (valid_tv_r)
    , .victim_way_o(victim_way)
  );

  icache_miss_ctrl miss_ctrl_i (
    .clk_i           (clk_i)
    , .reset_i       (reset_i)
    , .miss_i        (miss_tv)
    , .miss_addr_i   (paddr_tv_r)
    , .req_ready_i   (cache_req_ready_i)
    , .complete_i    (cache_req_complete_i)
    , .victim_way_i  (victim_way)
    , .req_o         (cache_req_o)
    , .req_v_o       (cache_req_v_o)
    , .meta_o        (cache_meta_o)
    , .meta_v_o      (cache_meta_v_o)
    , .lookup_ready_o(vaddr_ready_o)
  );

  // undo the bank swizzle, then pick the half by address bit 2
  assign word_sel = words_tv_r[hit_way ^ paddr_tv_r[byte_offset_width +: word_offset_width]];
  assign data_o = paddr_tv_r[byte_offset_width-1]
    ? word_sel[instr_width +: instr_width]
    : word_sel[instr_width-1:0];

endmodule

// File: tb/icache_tb.sv
// icache testbench
// lookups, fills and replacement checked against a reference model
`timescale 1ns/10ps

module icache_tb;

  import icache_pkg::*;

  localparam int clk_period = 40;
  localparam int lookup_count = 64;
  localparam index_t test_set = 6'd5;

  typedef struct packed {
    logic                   hit;
    way_t                   way;
    logic [instr_width-1:0] instr;
    way_t                   victim;
  } lookup_result_s;

  logic                   clk_i;
  logic                   reset_i;
  logic [vaddr_width-1:0] vaddr_i;
  logic                   vaddr_v_i;
  logic                   vaddr_ready_o;
  logic [ptag_width-1:0]  ptag_i;
  logic                   ptag_v_i;
  logic                   poison_i;
  logic [instr_width-1:0] data_o;
  logic                   data_v_o;
  logic                   miss_o;
  cache_req_s             cache_req_o;
  logic                   cache_req_v_o;
  logic                   cache_req_ready_i;
  cache_meta_s            cache_meta_o;
  logic                   cache_meta_v_o;
  logic                   cache_req_complete_i;
  data_pkt_s              data_pkt_i;
  logic                   data_pkt_v_i;
  logic                   data_pkt_ready_o;
  tag_pkt_s               tag_pkt_i;
  logic                   tag_pkt_v_i;
  logic                   tag_pkt_ready_o;

  // reference copy of the cache contents
  logic [block_width-1:0] ref_block [sets][ways];
  tag_t                   ref_tag   [sets][ways];
  logic [ways-1:0]        ref_valid [sets];
  lru_bits_t              ref_lru   [sets];

  // what the outputs should show in the current cycle
  logic                   exp_data_v;
  logic [instr_width-1:0] exp_data;
  logic                   exp_miss;
  logic                   exp_req_v;
  logic [paddr_width-1:0] exp_req_addr;
  logic                   exp_meta_v;
  way_t                   exp_meta_way;
  logic                   exp_pkt_ready;
  logic                   ready_chk;
  logic                   ready_exp;

  int          checks;
  int          errors;
  int unsigned tag_base;
  int          tag_count;

  icache dut_i (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  function automatic lookup_result_s ref_lookup(input logic [paddr_width-1:0] pa);
    lookup_result_s r;
    index_t         idx;
    lru_bits_t      lru;
    int             off;
    idx = pa[block_offset_width +: index_width];
    lru = ref_lru[idx];
    off = int'(pa[byte_offset_width +: word_offset_width]) * dword_width
      + int'(pa[2]) * instr_width;
    r = '0;
    for (int w = ways - 1; w >= 0; w--) begin
      if (ref_valid[idx][w] && ref_tag[idx][w] == pa[paddr_width-1 -: tag_width]) begin
        r.hit = 1'b1;
        r.way = way_t'(w);
      end
    end
    r.instr = ref_block[idx][r.way][off +: instr_width];
    // an empty way beats the tree
    r.victim = {lru[0], lru[1 + lru[0]]};
    for (int w = ways - 1; w >= 0; w--) begin
      if (!ref_valid[idx][w]) begin
        r.victim = way_t'(w);
      end
    end
    return r;
  endfunction

  function automatic tag_t next_tag();
    tag_count++;
    return tag_t'(tag_base + 32'(tag_count) * 17);
  endfunction

  function automatic logic [paddr_width-1:0] make_paddr(input tag_t tag, input index_t idx,
                                                       input logic [1:0] word, input logic half);
    return {tag, idx, word, half, 2'b00};
  endfunction

  task automatic send_tag_pkt(input tag_op_e op, input index_t idx, input way_t way,
                              input tag_t tag);
    tag_pkt_i = '{opcode: op, index: idx, way: way, tag: tag};
    tag_pkt_v_i = 1'b1;
    while (!tag_pkt_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    tag_pkt_v_i = 1'b0;
    if (op == tag_set_clear) begin
      ref_valid[idx] = '0;
    end else if (op == tag_invalidate) begin
      ref_valid[idx][way] = 1'b0;
    end else begin
      ref_tag[idx][way] = tag;
      ref_valid[idx][way] = 1'b1;
    end
  endtask

  // answer a fill request with a random block, then release the cache
  task automatic fill_block(input logic [paddr_width-1:0] pa, input way_t way);
    logic [block_width-1:0] blk;
    index_t                 idx;
    idx = pa[block_offset_width +: index_width];
    for (int i = 0; i < block_width / 32; i++) begin
      blk[i*32 +: 32] = $urandom();
    end
    data_pkt_i = '{index: idx, way: way, block: blk};
    data_pkt_v_i = 1'b1;
    while (!data_pkt_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    data_pkt_v_i = 1'b0;
    ref_block[idx][way] = blk;
    send_tag_pkt(tag_set_tag, idx, way, pa[paddr_width-1 -: tag_width]);
    cache_req_complete_i = 1'b1;
    @(negedge clk_i);
    cache_req_complete_i = 1'b0;
    ready_exp = 1'b1;
    @(negedge clk_i);
    ready_chk = 1'b0;
  endtask

  task automatic run_lookup(input logic [paddr_width-1:0] pa, input logic ptag_v,
                            input logic poison, output logic missed, output way_t meta_way);
    lookup_result_s res;
    logic           active;
    res = ref_lookup(pa);
    active = ptag_v & ~poison;
    missed = active & ~res.hit;
    // virtual page differs from the physical one
    vaddr_i = {~pa[paddr_width-1:page_offset_width], pa[page_offset_width-1:0]};
    vaddr_v_i = 1'b1;
    while (!vaddr_ready_o) @(negedge clk_i);
    // the arrays serve this lookup, so no packet is taken
    exp_pkt_ready = 1'b0;
    @(negedge clk_i);
    vaddr_v_i = 1'b0;
    exp_pkt_ready = 1'b1;
    ptag_i = pa[paddr_width-1:page_offset_width];
    ptag_v_i = ptag_v;
    poison_i = poison;
    @(negedge clk_i);
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    exp_data_v = active & res.hit;
    exp_data = res.instr;
    exp_miss = missed;
    exp_req_v = missed;
    exp_req_addr = {pa[paddr_width-1:block_offset_width], 5'b0};
    if (missed) begin
      ready_chk = 1'b1;
      ready_exp = 1'b0;
    end
    if (active && res.hit) begin
      ref_lru[pa[10:5]][0] = ~res.way[1];
      ref_lru[pa[10:5]][1 + res.way[1]] = ~res.way[0];
    end
    @(negedge clk_i);
    exp_data_v = 1'b0;
    exp_miss = 1'b0;
    exp_req_v = 1'b0;
    exp_meta_v = missed;
    exp_meta_way = res.victim;
    meta_way = cache_meta_o.repl_way;
    @(negedge clk_i);
    exp_meta_v = 1'b0;
  endtask

  task automatic access_block(input logic [paddr_width-1:0] pa);
    logic missed;
    way_t meta_way;
    run_lookup(pa, 1'b1, 1'b0, missed, meta_way);
    if (missed) begin
      fill_block(pa, meta_way);
      run_lookup(pa, 1'b1, 1'b0, missed, meta_way);
    end
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      check_eq("data_v_o", 64'(data_v_o), 64'(exp_data_v));
      check_eq("miss_o", 64'(miss_o), 64'(exp_miss));
      check_eq("cache_req_v_o", 64'(cache_req_v_o), 64'(exp_req_v));
      check_eq("cache_meta_v_o", 64'(cache_meta_v_o), 64'(exp_meta_v));
      check_eq("data_pkt_ready_o", 64'(data_pkt_ready_o), 64'(exp_pkt_ready));
      check_eq("tag_pkt_ready_o", 64'(tag_pkt_ready_o), 64'(exp_pkt_ready));
      if (exp_data_v) check_eq("data_o", 64'(data_o), 64'(exp_data));
      if (exp_req_v) check_eq("cache_req_o", 64'(cache_req_o.addr), 64'(exp_req_addr));
      if (exp_meta_v) check_eq("cache_meta_o", 64'(cache_meta_o.repl_way), 64'(exp_meta_way));
      if (ready_chk) check_eq("vaddr_ready_o", 64'(vaddr_ready_o), 64'(ready_exp));
    end
  end

  initial begin
    #(200 * lookup_count * clk_period);
    $display("watchdog timeout: the cache stopped answering");
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [paddr_width-1:0] pa;
    logic                   missed;
    way_t                   meta_way;
    int                     w;
    void'($urandom(46972));
    tag_base = $urandom();
    tag_count = 0;
    checks = 0;
    errors = 0;
    clk_i = 1'b0;
    reset_i = 1'b1;
    vaddr_i = '0;
    vaddr_v_i = 1'b0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    cache_req_ready_i = 1'b1;
    cache_req_complete_i = 1'b0;
    data_pkt_i = '0;
    data_pkt_v_i = 1'b0;
    tag_pkt_i = '0;
    tag_pkt_v_i = 1'b0;
    {exp_data_v, exp_data, exp_miss, exp_req_v, exp_req_addr} = '0;
    {exp_meta_v, exp_meta_way, ready_chk, ready_exp} = '0;
    exp_pkt_ready = 1'b1;
    for (int s = 0; s < sets; s++) begin
      ref_valid[s] = '0;
      ref_lru[s] = '0;
    end
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;

    for (int s = 0; s < sets; s++) begin
      send_tag_pkt(tag_set_clear, index_t'(s), way_t'(0), tag_t'(0));
    end
    // fill every way, then read each word and half back
    for (int k = 0; k < ways; k++) begin
      pa = make_paddr(next_tag(), test_set, 2'd0, 1'b0);
      access_block(pa);
      for (int off = 0; off < 8; off++) begin
        pa = make_paddr(pa[paddr_width-1 -: tag_width], test_set, off[2:1], off[0]);
        run_lookup(pa, 1'b1, 1'b0, missed, meta_way);
      end
    end
    // hits steer the tree, a new block then replaces its victim
    for (int r = 0; r < 4; r++) begin
      repeat (3) begin
        w = int'($urandom_range(ways - 1));
        pa = make_paddr(ref_tag[test_set][w], test_set, 2'($urandom_range(3)),
                        1'($urandom_range(1)));
        run_lookup(pa, 1'b1, 1'b0, missed, meta_way);
      end
      access_block(make_paddr(next_tag(), test_set, 2'd0, 1'b0));
    end
    w = int'($urandom_range(ways - 1));
    pa = make_paddr(ref_tag[test_set][w], test_set, 2'd1, 1'b1);
    send_tag_pkt(tag_invalidate, test_set, way_t'(w), tag_t'(0));
    access_block(pa);
    // lookups dropped in TL
    pa = make_paddr(ref_tag[test_set][0], test_set, 2'd2, 1'b0);
    run_lookup(pa, 1'b1, 1'b1, missed, meta_way);
    run_lookup(pa, 1'b0, 1'b0, missed, meta_way);

    repeat (2) @(negedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: all.f
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_banks.sv
design/icache_lru.sv
design/icache_miss_ctrl.sv
design/icache.sv
tb/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module icache_tb -o icache_sim

out=$(./obj_dir/icache_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
else
  exit 1
fi
